//--- Bender.yml
package:
  name: id_stage

sources:
  - common/isaPkg.sv
  - common/ctrlPkg.sv
  - hw/decode/instrDecoder.sv
  - hw/decode/immGen.sv
  - hw/regFile.sv
  - hw/idStage.sv
  - target: test
    files:
      - verif/idStage_props.sv
      - verif/idStageTb.sv

//--- common/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNeg = 4'd4,
        aluNot = 4'd5,
        aluSll = 4'd6,
        aluSra = 4'd8,
        aluCmp = 4'd9,
        aluSlt = 4'd10,
        aluPc  = 4'd11     // Passes the PC through
    } aluOp_e;

    // Operand B source
    typedef enum logic [1:0] {
        selReg  = 2'b00,
        selImm  = 2'b01,
        selNone = 2'b10
    } bSel_e;

    typedef enum logic [1:0] {
        memRead  = 2'b01,
        memWrite = 2'b10,
        memIdle  = 2'b11
    } memCtrl_e;

    typedef enum logic [1:0] {
        brAlways = 2'b00,
        brReg    = 2'b01,  // Target from readData1
        brEqz    = 2'b10,
        brNez    = 2'b11
    } branch_e;

    typedef enum logic [2:0] {
        immNone, sext11, sext8, zext8, sext5, sext4,
        shamt3             // Zero encodes a shift of 8
    } immFmt_e;

endpackage

//--- common/isaPkg.sv
package isaPkg;

    localparam int instrWidth    = 16;
    localparam int regIdxWidth   = 4;
    localparam int regFieldWidth = 3;   // rx, ry, rz in the encoding

    typedef logic [regIdxWidth-1:0] regIdx_t;

    // Instruction field positions
    localparam int opHi = 15;
    localparam int opLo = 11;
    localparam int rxLo = 8;
    localparam int ryLo = 5;
    localparam int rzLo = 2;

    typedef enum logic [4:0] {
        opNop     = 5'b00001,
        opB       = 5'b00010,
        opBeqz    = 5'b00100,
        opBnez    = 5'b00101,
        opShift   = 5'b00110,   // SLL, SRA
        opAddiu3  = 5'b01000,
        opAddiu   = 5'b01001,
        opSlti    = 5'b01011,
        opSpGroup = 5'b01100,   // ADDSP, BTEQZ, MTSP
        opLi      = 5'b01101,
        opMove    = 5'b01111,
        opLwsp    = 5'b10010,
        opLw      = 5'b10011,
        opSwsp    = 5'b11010,
        opSw      = 5'b11011,
        opRrr     = 5'b11100,   // ADDU, SUBU
        opRr      = 5'b11101,
        opIh      = 5'b11110    // MFIH, MTIH
    } opcode_e;

    localparam regIdx_t spReg   = 4'd8;
    localparam regIdx_t tReg    = 4'd9;
    localparam regIdx_t ihReg   = 4'd10;
    localparam regIdx_t zeroReg = 4'd15;

    ////////////////////////////////////////////////////////////////////////////
    // Sub-function codes

    localparam logic [1:0] shiftSll = 2'b00;   // instr[1:0]
    localparam logic [1:0] shiftSra = 2'b11;
    localparam logic [2:0] spBteqz  = 3'b000;  // instr[10:8]
    localparam logic [2:0] spAddsp  = 3'b011;
    localparam logic [2:0] spMtsp   = 3'b100;
    localparam logic [1:0] rrrAddu  = 2'b01;   // instr[1:0]
    localparam logic [1:0] rrrSubu  = 2'b11;
    localparam logic [4:0] rrJumpPc = 5'b00000; // instr[4:0], JR or MFPC by instr[7:5]
    localparam logic [4:0] rrSlt    = 5'b00010;
    localparam logic [4:0] rrCmp    = 5'b01010;
    localparam logic [4:0] rrNeg    = 5'b01011;
    localparam logic [4:0] rrAnd    = 5'b01100;
    localparam logic [4:0] rrOr     = 5'b01101;
    localparam logic [4:0] rrNot    = 5'b01111;
    localparam logic [2:0] rrJr     = 3'b000;
    localparam logic [2:0] rrMfpc   = 3'b010;
    localparam logic [7:0] ihMfih   = 8'h00;   // instr[7:0]
    localparam logic [7:0] ihMtih   = 8'h01;

endpackage

//--- hw/decode/immGen.sv
`timescale 1ns/1ns

module immGen import isaPkg::*, ctrlPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic [instrWidth-1:0] instr,
    input  immFmt_e               immFmt,
    output logic [dataWidth-1:0]  imm
);

    localparam int shamtLo    = 2;
    localparam int shamtWidth = 3;

    logic [shamtWidth-1:0] shamt;

    assign shamt = instr[shamtLo +: shamtWidth];

    always_comb begin
        case (immFmt)
            sext11: begin
                imm = {{(dataWidth-11){instr[10]}}, instr[10:0]};   // B offset
            end
            sext8: begin
                imm = {{(dataWidth-8){instr[7]}}, instr[7:0]};
            end
            zext8: begin
                imm = {{(dataWidth-8){1'b0}}, instr[7:0]};
            end
            sext5: begin
                imm = {{(dataWidth-5){instr[4]}}, instr[4:0]};      // LW, SW offset
            end
            sext4: begin
                imm = {{(dataWidth-4){instr[3]}}, instr[3:0]};
            end
            shamt3: begin
                if (shamt == '0) begin
                    imm = dataWidth'(8);
                end else begin
                    imm = {{(dataWidth-shamtWidth){1'b0}}, shamt};
                end
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- hw/decode/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import isaPkg::*, ctrlPkg::*; (
    input  logic [instrWidth-1:0] instr,
    output regIdx_t               readReg1,
    output regIdx_t               readReg2,
    output regIdx_t               writeReg,
    output aluOp_e                aluOp,
    output bSel_e                 bSel,
    output memCtrl_e              memCtrl,
    output branch_e               branchKind,
    output logic                  branchEn,
    output logic                  wbFromMem,
    output immFmt_e               immFmt
);

    opcode_e    op;
    regIdx_t    rx;
    regIdx_t    ry;
    regIdx_t    rz;
    logic [1:0] funct2;
    logic [2:0] funct3;
    logic [4:0] funct5;
    logic [7:0] funct8;

    assign op = opcode_e'(instr[opHi:opLo]);
    assign rx = regIdx_t'(instr[rxLo +: regFieldWidth]);
    assign ry = regIdx_t'(instr[ryLo +: regFieldWidth]);
    assign rz = regIdx_t'(instr[rzLo +: regFieldWidth]);

    assign funct2 = instr[1:0];
    assign funct3 = instr[ryLo +: 3];
    assign funct5 = instr[4:0];
    assign funct8 = instr[7:0];

    always_comb begin
        // Idle bundle
        readReg1   = zeroReg;
        readReg2   = zeroReg;
        writeReg   = zeroReg;
        aluOp      = aluAdd;
        bSel       = selNone;
        memCtrl    = memIdle;
        branchKind = brNez;
        branchEn   = 1'b0;
        wbFromMem  = 1'b0;
        immFmt     = immNone;

        case (op)
            opB: begin
                branchEn   = 1'b1;
                branchKind = brAlways;
                immFmt     = sext11;
            end
            opBeqz, opBnez: begin
                readReg1   = rx;
                aluOp      = aluSub;
                branchEn   = 1'b1;
                branchKind = (op == opBeqz) ? brEqz : brNez;
                immFmt     = sext8;
            end
            opShift: begin
                case (funct2)
                    shiftSll, shiftSra: begin
                        readReg1 = ry;
                        writeReg = rx;
                        bSel     = selImm;
                        aluOp    = (funct2 == shiftSll) ? aluSll : aluSra;
                        immFmt   = shamt3;
                    end
                    default: ;
                endcase
            end
            opAddiu3: begin
                readReg1 = rx;
                writeReg = ry;
                bSel     = selImm;
                immFmt   = sext4;
            end
            opAddiu: begin
                readReg1 = rx;
                writeReg = rx;
                bSel     = selImm;
                immFmt   = sext8;
            end
            opSlti: begin
                readReg1 = rx;
                writeReg = tReg;
                aluOp    = aluSlt;
                bSel     = selImm;
                immFmt   = zext8;
            end
            opSpGroup: begin
                case (instr[rxLo +: 3])
                    spAddsp: begin
                        readReg1 = spReg;
                        writeReg = spReg;
                        bSel     = selImm;
                        immFmt   = sext8;
                    end
                    spBteqz: begin
                        readReg1   = tReg;
                        aluOp      = aluSub;
                        branchEn   = 1'b1;
                        branchKind = brEqz;
                        immFmt     = sext8;
                    end
                    spMtsp: begin
                        readReg1 = ry;
                        writeReg = spReg;
                    end
                    default: ;
                endcase
            end
            opLi: begin
                writeReg = rx;
                bSel     = selImm;
                immFmt   = zext8;
            end
            opMove: begin
                readReg1 = ry;
                writeReg = rx;
                bSel     = selReg;   // Port 2 stays on the zero register
            end
            opLwsp, opLw: begin
                readReg1  = (op == opLwsp) ? spReg : rx;
                writeReg  = (op == opLwsp) ? rx : ry;
                bSel      = selImm;
                memCtrl   = memRead;
                wbFromMem = 1'b1;
                immFmt    = (op == opLwsp) ? sext8 : sext5;
            end
            opSwsp: begin
                readReg1 = spReg;
                readReg2 = rx;        // Store data
                memCtrl  = memWrite;
                immFmt   = sext8;
            end
            opSw: begin
                readReg1 = rx;
                readReg2 = ry;
                bSel     = selImm;
                memCtrl  = memWrite;
                immFmt   = sext5;
            end
            opRrr: begin
                case (funct2)
                    rrrAddu, rrrSubu: begin
                        readReg1 = rx;
                        readReg2 = ry;
                        writeReg = rz;
                        bSel     = selReg;
                        aluOp    = (funct2 == rrrAddu) ? aluAdd : aluSub;
                    end
                    default: ;
                endcase
            end
            opRr: begin
                case (funct5)
                    rrJumpPc: begin
                        if (funct3 == rrJr) begin
                            readReg1   = rx;
                            branchEn   = 1'b1;
                            branchKind = brReg;
                        end else if (funct3 == rrMfpc) begin
                            writeReg = rx;
                            aluOp    = aluPc;
                        end
                    end
                    rrSlt, rrCmp: begin
                        readReg1 = rx;
                        readReg2 = ry;
                        writeReg = tReg;
                        bSel     = selReg;
                        aluOp    = (funct5 == rrSlt) ? aluSlt : aluCmp;
                    end
                    rrNeg, rrNot: begin
                        readReg1 = ry;
                        writeReg = rx;
                        bSel     = (funct5 == rrNeg) ? selReg : selNone;
                        aluOp    = (funct5 == rrNeg) ? aluNeg : aluNot;
                    end
                    rrAnd, rrOr: begin
                        readReg1 = rx;
                        readReg2 = ry;
                        writeReg = rx;
                        bSel     = selReg;
                        aluOp    = (funct5 == rrAnd) ? aluAnd : aluOr;
                    end
                    default: ;
                endcase
            end
            opIh: begin
                if (funct8 == ihMfih) begin
                    readReg1 = ihReg;
                    writeReg = rx;
                end else if (funct8 == ihMtih) begin
                    readReg1 = rx;
                    writeReg = ihReg;
                end
            end
            default: ;   // NOP and unknown encodings stay idle
        endcase
    end

endmodule

//--- hw/idStage.sv
`timescale 1ns/1ns

module idStage import isaPkg::*, ctrlPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [instrWidth-1:0] instr,
    input  regIdx_t               writeBackReg,
    input  logic [dataWidth-1:0]  writeBackData,
    output aluOp_e                aluOp,
    output bSel_e                 bSel,
    output memCtrl_e              memCtrl,
    output branch_e               branchKind,
    output logic                  branchEn,
    output logic                  wbFromMem,
    output regIdx_t               writeReg,
    output regIdx_t               readReg1,
    output regIdx_t               readReg2,
    output logic [dataWidth-1:0]  imm,
    output logic [dataWidth-1:0]  readData1,
    output logic [dataWidth-1:0]  readData2
);

    regIdx_t              decReadReg1;
    regIdx_t              decReadReg2;
    regIdx_t              decWriteReg;
    aluOp_e               decAluOp;
    bSel_e                decBSel;
    memCtrl_e             decMemCtrl;
    branch_e              decBranchKind;
    logic                 decBranchEn;
    logic                 decWbFromMem;
    immFmt_e              decImmFmt;
    logic [dataWidth-1:0] decImm;
    logic [dataWidth-1:0] rfData1;
    logic [dataWidth-1:0] rfData2;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and register read

    instrDecoder decoder (
        .instr      (instr),
        .readReg1   (decReadReg1),
        .readReg2   (decReadReg2),
        .writeReg   (decWriteReg),
        .aluOp      (decAluOp),
        .bSel       (decBSel),
        .memCtrl    (decMemCtrl),
        .branchKind (decBranchKind),
        .branchEn   (decBranchEn),
        .wbFromMem  (decWbFromMem),
        .immFmt     (decImmFmt)
    );

    immGen #(.dataWidth(dataWidth)) immUnit (
        .instr  (instr),
        .immFmt (decImmFmt),
        .imm    (decImm)
    );

    regFile #(.dataWidth(dataWidth)) regs (
        .clk           (clk),
        .rst           (rst),
        .readReg1      (decReadReg1),
        .readReg2      (decReadReg2),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .readData1     (rfData1),
        .readData2     (rfData2)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX output register

    always_ff @(posedge clk) begin
        if (!rst) begin
            aluOp      <= aluAdd;
            bSel       <= selNone;
            memCtrl    <= memIdle;
            branchKind <= brNez;     // Same as the idle decode
            branchEn   <= 1'b0;
            wbFromMem  <= 1'b0;
            writeReg   <= zeroReg;
            readReg1   <= zeroReg;
            readReg2   <= zeroReg;
            imm        <= '0;
            readData1  <= '0;
            readData2  <= '0;
        end else begin
            aluOp      <= decAluOp;
            bSel       <= decBSel;
            memCtrl    <= decMemCtrl;
            branchKind <= decBranchKind;
            branchEn   <= decBranchEn;
            wbFromMem  <= decWbFromMem;
            writeReg   <= decWriteReg;
            readReg1   <= decReadReg1;
            readReg2   <= decReadReg2;
            imm        <= decImm;
            readData1  <= rfData1;
            readData2  <= rfData2;
        end
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ns

module regFile import isaPkg::*; #(
    parameter int dataWidth = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  regIdx_t              readReg1,
    input  regIdx_t              readReg2,
    input  regIdx_t              writeBackReg,
    input  logic [dataWidth-1:0] writeBackData,
    output logic [dataWidth-1:0] readData1,
    output logic [dataWidth-1:0] readData2
);

    localparam int numRegs = 2 ** regIdxWidth;

    logic [dataWidth-1:0] regs [numRegs];

    ////////////////////////////////////////////////////////////////////////////
    // Write port

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeBackReg != zeroReg) begin
            regs[writeBackReg] <= writeBackData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports

    // Zero register wins over forwarding
    always_comb begin
        if (readReg1 == zeroReg) begin
            readData1 = '0;
        end else if (readReg1 == writeBackReg) begin
            readData1 = writeBackData;
        end else begin
            readData1 = regs[readReg1];
        end
    end

    always_comb begin
        if (readReg2 == zeroReg) begin
            readData2 = '0;
        end else if (readReg2 == writeBackReg) begin
            readData2 = writeBackData;   // Same-cycle write-back
        end else begin
            readData2 = regs[readReg2];
        end
    end

endmodule

//--- sim.f
common/isaPkg.sv
common/ctrlPkg.sv
hw/decode/instrDecoder.sv
hw/decode/immGen.sv
hw/regFile.sv
hw/idStage.sv
verif/idStage_props.sv
verif/idStageTb.sv

//--- verif/idStageTb.sv
`timescale 1ns/1ns

module idStageTb import isaPkg::*, ctrlPkg::*;;

    localparam int resetCycles   = 10;
    localparam int randomCycles  = 500;
    localparam int timeoutCycles = 1000;   // Reset, ~60 directed, 500 random, plus margin

    typedef struct packed {
        logic [3:0]  aluOp;
        logic [1:0]  bSel;
        logic [1:0]  memCtrl;
        logic [1:0]  branchKind;
        logic        branchEn;
        logic        wbFromMem;
        logic [3:0]  writeReg;
        logic [3:0]  readReg1;
        logic [3:0]  readReg2;
        logic [15:0] imm;
    } bundle_t;

    localparam logic [4:0] validOps [18] = '{
        5'b00001, 5'b00010, 5'b00100, 5'b00101, 5'b00110, 5'b01000,
        5'b01001, 5'b01011, 5'b01100, 5'b01101, 5'b01111, 5'b10010,
        5'b10011, 5'b11010, 5'b11011, 5'b11100, 5'b11101, 5'b11110
    };

    // One per opcode and sub-function, plus invalid encodings
    localparam logic [15:0] directedInstrs [40] = '{
        16'h0800, 16'h17FF, 16'h1123, 16'h2380, 16'h2D12, 16'h3140, 16'h36F7, 16'h3141,
        16'h4289, 16'h4245, 16'h4FF0, 16'h4925, 16'h5B9C, 16'h63FE, 16'h6040, 16'h64A0,
        16'h6700, 16'h6CAB, 16'h7A60, 16'h9585, 16'h99D3, 16'hD37F, 16'hDC4A, 16'hE14D,
        16'hE7D7, 16'hE14C, 16'hEB00, 16'hEA40, 16'hEA20, 16'hE942, 16'hECAA, 16'hEE2B,
        16'hE8EF, 16'hEA6C, 16'hED8D, 16'hF300, 16'hF601, 16'hF302, 16'h0000, 16'hFFFF
    };

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] instr;
    regIdx_t     writeBackReg;
    logic [15:0] writeBackData;

    aluOp_e      aluOp;
    bSel_e       bSel;
    memCtrl_e    memCtrl;
    branch_e     branchKind;
    logic        branchEn;
    logic        wbFromMem;
    regIdx_t     writeReg;
    regIdx_t     readReg1;
    regIdx_t     readReg2;
    logic [15:0] imm;
    logic [15:0] readData1;
    logic [15:0] readData2;

    logic [15:0] model [16];   // Register file as the testbench sees it
    bundle_t     expBundle;
    logic [15:0] expData1;
    logic [15:0] expData2;
    logic        expValid = 1'b0;
    logic [31:0] lfsrState;
    int          cycles = 0;

    idStage #(.dataWidth(16)) UUT (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .aluOp         (aluOp),
        .bSel          (bSel),
        .memCtrl       (memCtrl),
        .branchKind    (branchKind),
        .branchEn      (branchEn),
        .wbFromMem     (wbFromMem),
        .writeReg      (writeReg),
        .readReg1      (readReg1),
        .readReg2      (readReg2),
        .imm           (imm),
        .readData1     (readData1),
        .readData2     (readData2)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = stepLfsr(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic [15:0] signExtend(input logic [15:0] raw, input int width);
        logic signed [15:0] t;
        t = raw << (16 - width);
        return t >>> (16 - width);
    endfunction

    function automatic bundle_t idleBundle();
        bundle_t b;
        b.aluOp      = aluAdd;
        b.bSel       = selNone;
        b.memCtrl    = memIdle;
        b.branchKind = brNez;
        b.branchEn   = 1'b0;
        b.wbFromMem  = 1'b0;
        b.writeReg   = zeroReg;
        b.readReg1   = zeroReg;
        b.readReg2   = zeroReg;
        b.imm        = '0;
        return b;
    endfunction

    function automatic bundle_t decodeRef(input logic [15:0] i);
        bundle_t    b;
        logic [3:0] rx;
        logic [3:0] ry;
        logic [3:0] rz;
        rx = {1'b0, i[10:8]};
        ry = {1'b0, i[7:5]};
        rz = {1'b0, i[4:2]};
        b = idleBundle();
        case (i[15:11])
            5'b00010: begin   // B
                b.branchEn   = 1'b1;
                b.branchKind = brAlways;
                b.imm        = signExtend(i, 11);
            end
            5'b00100, 5'b00101: begin   // BEQZ, BNEZ
                b.readReg1   = rx;
                b.aluOp      = aluSub;
                b.branchEn   = 1'b1;
                b.branchKind = i[11] ? brNez : brEqz;
                b.imm        = signExtend(i, 8);
            end
            5'b00110: begin
                if (i[1:0] == 2'b00 || i[1:0] == 2'b11) begin
                    b.readReg1 = ry;
                    b.writeReg = rx;
                    b.bSel     = selImm;
                    b.aluOp    = i[0] ? aluSra : aluSll;
                    b.imm      = (i[4:2] == 3'd0) ? 16'd8 : {13'd0, i[4:2]};
                end
            end
            5'b01000: begin   // ADDIU3
                b.readReg1 = rx;
                b.writeReg = ry;
                b.bSel     = selImm;
                b.imm      = signExtend(i, 4);
            end
            5'b01001: begin
                b.readReg1 = rx;
                b.writeReg = rx;
                b.bSel     = selImm;
                b.imm      = signExtend(i, 8);
            end
            5'b01011: begin   // SLTI
                b.readReg1 = rx;
                b.writeReg = tReg;
                b.aluOp    = aluSlt;
                b.bSel     = selImm;
                b.imm      = {8'd0, i[7:0]};
            end
            5'b01100: begin
                if (i[10:8] == 3'b011) begin   // ADDSP
                    b.readReg1 = spReg;
                    b.writeReg = spReg;
                    b.bSel     = selImm;
                    b.imm      = signExtend(i, 8);
                end else if (i[10:8] == 3'b000) begin   // BTEQZ
                    b.readReg1   = tReg;
                    b.aluOp      = aluSub;
                    b.branchEn   = 1'b1;
                    b.branchKind = brEqz;
                    b.imm        = signExtend(i, 8);
                end else if (i[10:8] == 3'b100) begin   // MTSP
                    b.readReg1 = ry;
                    b.writeReg = spReg;
                end
            end
            5'b01101: begin   // LI
                b.writeReg = rx;
                b.bSel     = selImm;
                b.imm      = {8'd0, i[7:0]};
            end
            5'b01111: begin   // MOVE
                b.readReg1 = ry;
                b.writeReg = rx;
                b.bSel     = selReg;
            end
            5'b10010, 5'b10011: begin   // LWSP, LW
                b.readReg1  = i[11] ? rx : spReg;
                b.writeReg  = i[11] ? ry : rx;
                b.bSel      = selImm;
                b.memCtrl   = memRead;
                b.wbFromMem = 1'b1;
                b.imm       = i[11] ? signExtend(i, 5) : signExtend(i, 8);
            end
            5'b11010: begin   // SWSP
                b.readReg1 = spReg;
                b.readReg2 = rx;
                b.memCtrl  = memWrite;
                b.imm      = signExtend(i, 8);
            end
            5'b11011: begin
                b.readReg1 = rx;
                b.readReg2 = ry;
                b.bSel     = selImm;
                b.memCtrl  = memWrite;
                b.imm      = signExtend(i, 5);
            end
            5'b11100: begin
                if (i[0]) begin   // ADDU, SUBU
                    b.readReg1 = rx;
                    b.readReg2 = ry;
                    b.writeReg = rz;
                    b.bSel     = selReg;
                    b.aluOp    = i[1] ? aluSub : aluAdd;
                end
            end
            5'b11101: begin
                case (i[4:0])
                    5'b00000: begin
                        if (i[7:5] == 3'b000) begin   // JR
                            b.readReg1   = rx;
                            b.branchEn   = 1'b1;
                            b.branchKind = brReg;
                        end else if (i[7:5] == 3'b010) begin   // MFPC
                            b.writeReg = rx;
                            b.aluOp    = aluPc;
                        end
                    end
                    5'b00010, 5'b01010: begin   // SLT, CMP
                        b.readReg1 = rx;
                        b.readReg2 = ry;
                        b.writeReg = tReg;
                        b.bSel     = selReg;
                        b.aluOp    = i[3] ? aluCmp : aluSlt;
                    end
                    5'b01011: begin
                        b.readReg1 = ry;
                        b.writeReg = rx;
                        b.bSel     = selReg;
                        b.aluOp    = aluNeg;
                    end
                    5'b01111: begin
                        b.readReg1 = ry;
                        b.writeReg = rx;
                        b.aluOp    = aluNot;
                    end
                    5'b01100, 5'b01101: begin   // AND, OR
                        b.readReg1 = rx;
                        b.readReg2 = ry;
                        b.writeReg = rx;
                        b.bSel     = selReg;
                        b.aluOp    = i[0] ? aluOr : aluAnd;
                    end
                    default: ;
                endcase
            end
            5'b11110: begin
                if (i[7:0] == 8'h00) begin   // MFIH
                    b.readReg1 = ihReg;
                    b.writeReg = rx;
                end else if (i[7:0] == 8'h01) begin
                    b.readReg1 = rx;
                    b.writeReg = ihReg;
                end
            end
            default: ;
        endcase
        return b;
    endfunction

    // Zero register, then same-cycle write-back, then stored value
    function automatic logic [15:0] modelRead(input logic [3:0] idx);
        if (idx == zeroReg) begin
            return '0;
        end else if (idx == writeBackReg) begin
            return writeBackData;
        end
        return model[idx];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Expected values and comparison

    always @(posedge clk) begin
        if (!rst) begin
            expBundle = idleBundle();
            expData1 = '0;
            expData2 = '0;
            for (int k = 0; k < 16; k++) begin
                model[k] = '0;
            end
        end else begin
            expBundle = decodeRef(instr);
            expData1 = modelRead(expBundle.readReg1);
            expData2 = modelRead(expBundle.readReg2);
            if (writeBackReg != zeroReg) begin
                model[writeBackReg] = writeBackData;
            end
        end
        expValid = 1'b1;
    end

    task automatic checkField(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp)
        else begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, exp, got);
            $display("Test failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Outputs are registered, so they are settled at the falling edge
    always @(negedge clk) begin
        if (expValid) begin
            checkField("aluOp", aluOp, expBundle.aluOp);
            checkField("bSel", bSel, expBundle.bSel);
            checkField("memCtrl", memCtrl, expBundle.memCtrl);
            checkField("branchKind", branchKind, expBundle.branchKind);
            checkField("branchEn", branchEn, expBundle.branchEn);
            checkField("wbFromMem", wbFromMem, expBundle.wbFromMem);
            checkField("writeReg", writeReg, expBundle.writeReg);
            checkField("readReg1", readReg1, expBundle.readReg1);
            checkField("readReg2", readReg2, expBundle.readReg2);
            checkField("imm", imm, expBundle.imm);
            checkField("readData1", readData1, expData1);
            checkField("readData2", readData2, expData2);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic drive(input logic [15:0] i, input logic [3:0] r, input logic [15:0] d);
        @(negedge clk);
        instr         = i;
        writeBackReg  = r;
        writeBackData = d;
    endtask

    initial begin
        logic [31:0] bits;
        logic [15:0] newInstr;
        logic [3:0]  newReg;
        rst           = 1'b0;
        instr         = 16'h0800;   // NOP
        writeBackReg  = zeroReg;
        writeBackData = '0;
        lfsrState     = 32'h0247_1bbc;

        repeat (resetCycles) @(negedge clk);
        rst = 1'b1;

        // Fill every register, index 15 included
        for (int r = 0; r < 16; r++) begin
            drive(16'h0800, r[3:0], {r[3:0], 4'hA, r[3:0], 4'h5});
        end
        for (int k = 0; k < 8; k++) begin
            drive({5'b01111, 3'd0, k[2:0], 5'd0}, zeroReg, 16'h0000);   // MOVE r0, rk
        end

        // Forwarding on both read ports
        drive(16'h7880, 4'd4, 16'hBEEF);
        drive(16'hDC4A, 4'd2, 16'h5A5A);

        foreach (directedInstrs[n]) begin
            drive(directedInstrs[n], zeroReg, 16'h0000);
        end

        for (int n = 0; n < randomCycles; n++) begin
            bits = nextBits(16);
            newInstr = bits[15:0];
            if (nextBits(1) == 32'd1) begin
                newInstr[15:11] = validOps[nextBits(5) % 18];
            end
            bits = nextBits(4);
            newReg = bits[3:0];
            bits = nextBits(16);
            drive(newInstr, newReg, bits[15:0]);
        end

        drive(16'h0800, zeroReg, 16'h0000);
        repeat (3) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- verif/idStage_props.sv
`timescale 1ns/1ns

module idStage_props import isaPkg::*, ctrlPkg::*; (
    input logic     clk,
    input logic     rst,
    input memCtrl_e memCtrl,
    input logic     branchEn,
    input logic     wbFromMem,
    input regIdx_t  writeReg
);

    property idleAfterReset;
        @(posedge clk) !rst |=> (!branchEn && !wbFromMem && memCtrl == memIdle
                                 && writeReg == zeroReg);
    endproperty

    property loadWritesFromMem;
        @(posedge clk) disable iff (!rst) memCtrl == memRead |-> wbFromMem;
    endproperty

    property branchNoMemAccess;
        @(posedge clk) disable iff (!rst) branchEn |-> memCtrl == memIdle;
    endproperty

    // Stores have no destination register
    property storeNoWriteBack;
        @(posedge clk) disable iff (!rst) memCtrl == memWrite |-> writeReg == zeroReg;
    endproperty

    assert property (idleAfterReset) else $error("Outputs not idle after a reset cycle");
    assert property (loadWritesFromMem) else $error("Load without write-back from memory");
    assert property (branchNoMemAccess) else $error("Branch with a memory access");
    assert property (storeNoWriteBack) else $error("Store with a destination register");

endmodule

bind idStage idStage_props props (
    .clk       (clk),
    .rst       (rst),
    .memCtrl   (memCtrl),
    .branchEn  (branchEn),
    .wbFromMem (wbFromMem),
    .writeReg  (writeReg)
);
